// ==== i2c_bus_pkg.sv ====
package i2c_bus_pkg;

	// Clocks per SCL half period; a full bit is two of these
	localparam int half_bit_cycles = 8;

	// Flops in front of the edge detectors on SCL and SDA
	localparam int sync_stages = 2;

	// Wide enough for the start state, which spans two half periods
	localparam int phase_cnt_w = $clog2(2 * half_bit_cycles);

	// Each bit set means pull that line low
	typedef struct packed {
		logic scl_pd;
		logic sda_pd;
	} i2c_pad_t;

	typedef struct packed {
		logic [7:0] data;
		logic       last;
	} tx_byte_t;

	typedef struct packed {
		logic [7:0] data;
		logic       first;
	} rx_byte_t;

	typedef enum logic [3:0] {
		tx_idle,
		tx_start,
		tx_bit_low,
		tx_bit_high,
		tx_ack_low,
		tx_ack_high,
		tx_hold,
		tx_stop_low,
		tx_stop_mid,
		tx_stop_high
	} tx_state_e;

	typedef enum logic [1:0] {
		mon_idle,
		mon_data,
		mon_ack
	} rx_state_e;

endpackage

// ==== host_reg_pkg.sv ====
package host_reg_pkg;

	// Depth of both the transmit and the receive byte queue
	localparam int fifo_depth = 4;

	localparam logic [1:0] axi_okay = 2'b00;

	// Status word bit positions
	localparam int status_busy = 0;
	localparam int status_last_nack = 1;
	localparam int status_tx_full = 2;
	localparam int status_rx_empty = 3;
	localparam int status_rx_overflow = 4;

	// Flag bits in the data registers
	localparam int tx_last_bit = 8;
	localparam int rx_first_bit = 8;
	localparam int rx_valid_bit = 9;

	typedef struct packed {
		logic        awvalid;
		logic [3:0]  awaddr;
		logic        wvalid;
		logic [31:0] wdata;
		logic        bready;
		logic        arvalid;
		logic [3:0]  araddr;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	typedef enum logic [3:0] {
		reg_tx_data   = 4'h0,
		reg_rx_data   = 4'h4,
		reg_status    = 4'h8,
		reg_match_row = 4'hC
	} reg_offset_e;

endpackage

// ==== byte_fifo.sv ====
module byte_fifo #(
	parameter int depth = 4,
	parameter int width = 9
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             push,
	input  logic [width-1:0] push_data,
	input  logic             pop,
	output logic [width-1:0] head,
	output logic             valid,
	output logic             full
);
	logic [width-1:0]               mem [depth];
	logic [$clog2(depth)-1:0]       wr_ptr;
	logic [$clog2(depth)-1:0]       rd_ptr;
	logic [$clog2(depth + 1)-1:0]   count;
	logic                           do_push;
	logic                           do_pop;

	assign valid = (count != '0);
	assign full = (int'(count) == depth);
	assign head = mem[rd_ptr];

	// Guard both sides so a stray request never corrupts the count
	assign do_push = push && !full;
	assign do_pop = pop && valid;

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (int'(wr_ptr) == depth - 1) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (int'(rd_ptr) == depth - 1) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== axil_host_regs.sv ====
module axil_host_regs (
	input  logic                    clk,
	input  logic                    reset,
	input  host_reg_pkg::axil_req_t req,
	output host_reg_pkg::axil_rsp_t rsp,
	input  logic                    tx_full,
	output logic                    tx_push,
	output i2c_bus_pkg::tx_byte_t   tx_data,
	input  i2c_bus_pkg::rx_byte_t   rx_head,
	input  logic                    rx_valid,
	output logic                    rx_pop,
	output logic                    match_we,
	output logic [3:0]              match_row,
	output logic [7:0]              match_bits,
	input  logic                    busy,
	input  logic                    last_nack,
	input  logic                    rx_overflow_pulse
);
	import host_reg_pkg::*;

	reg_offset_e wr_offset;
	reg_offset_e rd_offset;
	logic        tx_stall;
	logic        wr_accept;
	logic        rd_accept;
	logic        bvalid_q;
	logic        rvalid_q;
	logic [31:0] rdata_q;
	logic        overflow_sticky;
	logic [31:0] status_word;
	logic [31:0] rx_word;

	assign wr_offset = reg_offset_e'(req.awaddr);
	assign rd_offset = reg_offset_e'(req.araddr);

	// A byte write waits while the transmit queue has no room
	assign tx_stall = (wr_offset == reg_tx_data) && tx_full;
	assign wr_accept = req.awvalid && req.wvalid && !bvalid_q && !tx_stall;
	assign rd_accept = req.arvalid && !rvalid_q;

	assign tx_push = wr_accept && (wr_offset == reg_tx_data);
	assign tx_data = '{data: req.wdata[7:0], last: req.wdata[tx_last_bit]};

	// Match row layout is the row in bits 3:0 and the allow mask in bits 15:8
	assign match_we = wr_accept && (wr_offset == reg_match_row);
	assign match_row = req.wdata[3:0];
	assign match_bits = req.wdata[15:8];

	assign rx_pop = rd_accept && (rd_offset == reg_rx_data) && rx_valid;

	always_comb begin
		status_word = '0;
		status_word[status_busy] = busy;
		status_word[status_last_nack] = last_nack;
		status_word[status_tx_full] = tx_full;
		status_word[status_rx_empty] = !rx_valid;
		status_word[status_rx_overflow] = overflow_sticky;
	end

	always_comb begin
		rx_word = '0;
		if (rx_valid) begin
			rx_word[7:0] = rx_head.data;
			rx_word[rx_first_bit] = rx_head.first;
			rx_word[rx_valid_bit] = 1'b1;
		end
	end

	assign rsp = '{
		awready: wr_accept,
		wready:  wr_accept,
		bvalid:  bvalid_q,
		bresp:   axi_okay,
		arready: rd_accept,
		rvalid:  rvalid_q,
		rdata:   rdata_q,
		rresp:   axi_okay
	};

	always_ff @(posedge clk) begin
		if (reset) begin
			bvalid_q <= 1'b0;
			rvalid_q <= 1'b0;
			overflow_sticky <= 1'b0;
		end else begin
			if (wr_accept)
				bvalid_q <= 1'b1;
			else if (req.bready)
				bvalid_q <= 1'b0;

			if (rd_accept)
				rvalid_q <= 1'b1;
			else if (req.rready)
				rvalid_q <= 1'b0;

			// A new drop in the same cycle as the status read keeps the bit set
			if (rx_overflow_pulse)
				overflow_sticky <= 1'b1;
			else if (rd_accept && rd_offset == reg_status)
				overflow_sticky <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rd_accept) begin
			case (rd_offset)
				reg_rx_data: rdata_q <= rx_word;
				reg_status:  rdata_q <= status_word;
				default:     rdata_q <= '0;
			endcase
		end
	end

endmodule

// ==== i2c_master_tx.sv ====
module i2c_master_tx (
	input  logic                  clk,
	input  logic                  reset,
	input  i2c_bus_pkg::tx_byte_t byte_in,
	input  logic                  byte_valid,
	input  logic                  sda_in,
	output logic                  byte_pop,
	output i2c_bus_pkg::i2c_pad_t pad,
	output logic                  busy,
	output logic                  last_nack
);
	import i2c_bus_pkg::*;

	tx_state_e              state;
	logic [phase_cnt_w-1:0] cnt;
	logic [2:0]             bit_idx;
	logic                   flush;
	logic                   phase_end;
	logic                   ack_sample;
	logic                   late_low;
	logic                   scl_low;
	logic                   sda_low;
	logic                   sda_update;

	// Start is the only state that spans two half periods
	assign phase_end = (state == tx_start) ?
		(int'(cnt) == 2 * half_bit_cycles - 1) : (int'(cnt) == half_bit_cycles - 1);

	// SDA moves a quarter bit after SCL has gone low
	assign late_low = (int'(cnt) >= half_bit_cycles / 2);

	assign ack_sample = (state == tx_ack_high) && phase_end;
	assign byte_pop = ack_sample || (state == tx_idle && flush && byte_valid);
	assign busy = (state != tx_idle) || flush;

	always_comb begin
		scl_low = 1'b0;
		sda_low = 1'b0;
		sda_update = 1'b1;
		case (state)
			tx_start: sda_low = (int'(cnt) >= half_bit_cycles);
			tx_bit_low: begin
				scl_low = 1'b1;
				sda_low = byte_valid && !byte_in.data[bit_idx];
				sda_update = late_low;
			end
			tx_bit_high: sda_low = !byte_in.data[bit_idx];
			tx_ack_low: begin
				scl_low = 1'b1;
				sda_update = late_low;
			end
			tx_hold: scl_low = 1'b1;
			tx_stop_low: begin
				scl_low = 1'b1;
				sda_low = 1'b1;
				sda_update = late_low;
			end
			tx_stop_mid: sda_low = 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= tx_idle;
			cnt <= '0;
			bit_idx <= 3'd7;
			flush <= 1'b0;
			last_nack <= 1'b0;
			pad <= '0;
		end else begin
			pad.scl_pd <= scl_low;
			if (sda_update)
				pad.sda_pd <= sda_low;
			if (cnt != '1)
				cnt <= cnt + 1'b1;

			case (state)
				tx_idle: begin
					cnt <= '0;
					// After a nack the rest of that transaction is dropped
					if (flush) begin
						if (byte_valid && byte_in.last)
							flush <= 1'b0;
					end else if (byte_valid) begin
						state <= tx_start;
					end
				end
				tx_start: if (phase_end) begin
					state <= tx_bit_low;
					cnt <= '0;
					bit_idx <= 3'd7;
				end
				tx_bit_low: begin
					// Next byte not queued yet, so stretch the low phase
					if (!byte_valid) begin
						state <= tx_hold;
						cnt <= '0;
					end else if (phase_end) begin
						state <= tx_bit_high;
						cnt <= '0;
					end
				end
				tx_bit_high: if (phase_end) begin
					cnt <= '0;
					bit_idx <= bit_idx - 1'b1;
					state <= (bit_idx == 3'd0) ? tx_ack_low : tx_bit_low;
				end
				tx_ack_low: if (phase_end) begin
					state <= tx_ack_high;
					cnt <= '0;
				end
				tx_ack_high: if (phase_end) begin
					cnt <= '0;
					last_nack <= sda_in;
					if (sda_in) begin
						flush <= !byte_in.last;
						state <= tx_stop_low;
					end else if (byte_in.last) begin
						state <= tx_stop_low;
					end else begin
						state <= tx_bit_low;
					end
				end
				tx_hold: if (byte_valid) begin
					state <= tx_bit_low;
					cnt <= '0;
				end
				tx_stop_low: if (phase_end) begin
					state <= tx_stop_mid;
					cnt <= '0;
				end
				tx_stop_mid: if (phase_end) begin
					state <= tx_stop_high;
					cnt <= '0;
				end
				tx_stop_high: if (phase_end) begin
					state <= tx_idle;
					cnt <= '0;
				end
				default: state <= tx_idle;
			endcase
		end
	end

endmodule

// ==== i2c_bus_monitor.sv ====
module i2c_bus_monitor (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  scl_in,
	input  logic                  sda_in,
	input  logic                  match_we,
	input  logic [3:0]            match_row,
	input  logic [7:0]            match_bits,
	input  logic                  rx_full,
	output logic                  sda_pd,
	output logic                  rx_push,
	output i2c_bus_pkg::rx_byte_t rx_data,
	output logic                  overflow_pulse
);
	import i2c_bus_pkg::*;

	logic [sync_stages-1:0] scl_sync;
	logic [sync_stages-1:0] sda_sync;
	logic                   scl_s;
	logic                   sda_s;
	logic                   scl_q;
	logic                   sda_q;
	logic                   start_det;
	logic                   stop_det;
	logic                   scl_rise;
	logic                   scl_fall;
	logic [7:0]             match_table [16];
	rx_state_e              state;
	logic [3:0]             bit_cnt;
	logic [7:0]             shift;
	logic [7:0]             next_byte;
	logic                   first_byte;
	logic                   matched;
	logic                   hit;

	assign scl_s = scl_sync[sync_stages-1];
	assign sda_s = sda_sync[sync_stages-1];

	// SDA may only move with SCL high at a start or a stop
	assign start_det = scl_s && scl_q && sda_q && !sda_s;
	assign stop_det = scl_s && scl_q && !sda_q && sda_s;
	assign scl_rise = scl_s && !scl_q;
	assign scl_fall = !scl_s && scl_q;

	assign next_byte = {shift[6:0], sda_s};

	// Address bits 6:3 pick the row and bits 2:0 the column; bit 0 of the byte is R/W
	assign hit = first_byte ? match_table[next_byte[7:4]][next_byte[3:1]] : matched;

	always_ff @(posedge clk) begin
		scl_sync <= {scl_sync[sync_stages-2:0], scl_in};
		sda_sync <= {sda_sync[sync_stages-2:0], sda_in};
		scl_q <= scl_s;
		sda_q <= sda_s;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 16; i++)
				match_table[i] <= '0;
		end else if (match_we) begin
			match_table[match_row] <= match_bits;
		end
	end

	always_ff @(posedge clk) begin
		if (state == mon_data && scl_rise && bit_cnt == 4'd7)
			rx_data <= '{data: next_byte, first: first_byte};
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= mon_idle;
			bit_cnt <= '0;
			shift <= '0;
			first_byte <= 1'b0;
			matched <= 1'b0;
			sda_pd <= 1'b0;
			rx_push <= 1'b0;
			overflow_pulse <= 1'b0;
		end else begin
			rx_push <= 1'b0;
			overflow_pulse <= 1'b0;
			if (start_det) begin
				state <= mon_data;
				bit_cnt <= '0;
				first_byte <= 1'b1;
				matched <= 1'b0;
				sda_pd <= 1'b0;
			end else if (stop_det) begin
				state <= mon_idle;
				sda_pd <= 1'b0;
			end else begin
				case (state)
					mon_data: if (scl_rise) begin
						shift <= next_byte;
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 4'd7) begin
							state <= mon_ack;
							matched <= hit;
							if (hit) begin
								rx_push <= !rx_full;
								overflow_pulse <= rx_full;
							end
						end
					end
					mon_ack: if (scl_fall) begin
						// First fall opens the ack slot, the second one closes it
						if (bit_cnt == 4'd8) begin
							sda_pd <= matched;
							bit_cnt <= 4'd9;
						end else begin
							sda_pd <= 1'b0;
							bit_cnt <= '0;
							first_byte <= 1'b0;
							state <= mon_data;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== i2c_bridge_top.sv ====
module i2c_bridge_top (
	input  logic                    clk,
	input  logic                    reset,
	input  host_reg_pkg::axil_req_t host_req,
	output host_reg_pkg::axil_rsp_t host_rsp,
	input  logic                    scl_in,
	input  logic                    sda_in,
	output logic                    scl_pd,
	output logic                    scl_tri,
	output logic                    sda_pd,
	output logic                    sda_tri
);
	import host_reg_pkg::*;
	import i2c_bus_pkg::*;

	tx_byte_t   tx_data;
	tx_byte_t   tx_head;
	rx_byte_t   rx_data;
	rx_byte_t   rx_head;
	i2c_pad_t   eng_pad;
	logic       tx_push;
	logic       tx_pop;
	logic       tx_valid;
	logic       tx_full;
	logic       rx_push;
	logic       rx_pop;
	logic       rx_valid;
	logic       rx_full;
	logic       match_we;
	logic [3:0] match_row;
	logic [7:0] match_bits;
	logic       busy;
	logic       last_nack;
	logic       overflow_pulse;
	logic       mon_sda_pd;

	axil_host_regs regs (
		.clk(clk), .reset(reset), .req(host_req), .rsp(host_rsp),
		.tx_full(tx_full), .tx_push(tx_push), .tx_data(tx_data),
		.rx_head(rx_head), .rx_valid(rx_valid), .rx_pop(rx_pop),
		.match_we(match_we), .match_row(match_row), .match_bits(match_bits),
		.busy(busy), .last_nack(last_nack), .rx_overflow_pulse(overflow_pulse)
	);

	byte_fifo #(.depth(fifo_depth), .width($bits(tx_byte_t))) tx_fifo (
		.clk(clk), .reset(reset), .push(tx_push), .push_data(tx_data),
		.pop(tx_pop), .head(tx_head), .valid(tx_valid), .full(tx_full)
	);

	i2c_master_tx engine (
		.clk(clk), .reset(reset), .byte_in(tx_head), .byte_valid(tx_valid),
		.sda_in(sda_in), .byte_pop(tx_pop), .pad(eng_pad),
		.busy(busy), .last_nack(last_nack)
	);

	i2c_bus_monitor monitor (
		.clk(clk), .reset(reset), .scl_in(scl_in), .sda_in(sda_in),
		.match_we(match_we), .match_row(match_row), .match_bits(match_bits),
		.rx_full(rx_full), .sda_pd(mon_sda_pd), .rx_push(rx_push),
		.rx_data(rx_data), .overflow_pulse(overflow_pulse)
	);

	byte_fifo #(.depth(fifo_depth), .width($bits(rx_byte_t))) rx_fifo (
		.clk(clk), .reset(reset), .push(rx_push), .push_data(rx_data),
		.pop(rx_pop), .head(rx_head), .valid(rx_valid), .full(rx_full)
	);

	// Open drain pads: the driver is enabled only while pulling low
	assign scl_pd = eng_pad.scl_pd;
	assign sda_pd = eng_pad.sda_pd | mon_sda_pd;
	assign scl_tri = !scl_pd;
	assign sda_tri = !sda_pd;

endmodule

// ==== tb_i2c_bridge.sv ====
module tb_i2c_bridge;
	timeunit 1ns;
	timeprecision 100ps;

	import host_reg_pkg::*;
	import i2c_bus_pkg::*;

	localparam int bit_cycles = 2 * half_bit_cycles;
	// Six transactions of up to eight bytes, nine bits each, plus half again as margin
	localparam int timeout_cycles = 6 * 8 * 9 * bit_cycles * 3 / 2;
	localparam logic [6:0] allowed_addr = 7'h2A;
	localparam logic [6:0] blocked_addr = 7'h2B;

	logic      clk = 1'b0;
	logic      reset;
	axil_req_t req;
	axil_rsp_t rsp;
	logic      scl_pd;
	logic      scl_tri;
	logic      sda_pd;
	logic      sda_tri;
	logic      scl_line;
	logic      sda_line;

	integer      seed;
	string       test_name;
	int          cycle_count = 0;
	int          error_count = 0;
	int          errors_at_start;
	int          tests_run = 0;
	int          tests_failed = 0;
	int          issued = 0;
	int          start_count = 0;
	int          stop_count = 0;
	int          scl_rises = 0;
	int          high_cycles;
	logic        scl_prev = 1'b1;
	logic        sda_prev = 1'b1;
	logic        bus_active = 1'b0;
	logic [7:0]  sent [6];
	logic [31:0] word;

	i2c_bridge_top dut (
		.clk(clk), .reset(reset), .host_req(req), .host_rsp(rsp),
		.scl_in(scl_line), .sda_in(sda_line),
		.scl_pd(scl_pd), .scl_tri(scl_tri), .sda_pd(sda_pd), .sda_tri(sda_tri)
	);

	// Wired-AND bus with pull-ups, a line is low only while some pad pulls it
	assign scl_line = (scl_pd === 1'b1) ? 1'b0 : 1'b1;
	assign sda_line = (sda_pd === 1'b1) ? 1'b0 : 1'b1;

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			$display("Timeout: the run was still going after %0d cycles", cycle_count);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	task automatic report_error(input string msg);
		$display("ERROR in %s: %s", test_name, msg);
		error_count++;
	endtask

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("FAIL %s, %s: expected 0x%0h, actual 0x%0h",
				test_name, what, expected, actual);
			error_count++;
		end
	endtask

	// The engine keeps SCL low for as long as it waits for the next byte
	hold_scl_low: assert property (@(posedge clk) disable iff (reset)
		dut.engine.state == tx_hold |-> !scl_line)
		else report_error("SCL was released while the engine held the bus");

	pad_enables: assert property (@(posedge clk) disable iff (reset)
		scl_tri == !scl_pd && sda_tri == !sda_pd)
		else report_error("a tristate enable does not match its pull-down");

	// Line decoder: SDA may only move with SCL high at a start or a stop
	always @(posedge clk) begin
		if (reset) begin
			scl_prev <= 1'b1;
			sda_prev <= 1'b1;
			bus_active <= 1'b0;
		end else begin
			scl_prev <= scl_line;
			sda_prev <= sda_line;
			if (!scl_prev && scl_line) begin
				scl_rises <= scl_rises + 1;
				assert (sda_line == sda_prev) else report_error("SDA moved as SCL rose");
			end
			if (scl_prev && scl_line && sda_prev && !sda_line) begin
				assert (!bus_active) else report_error("start condition inside a transaction");
				start_count <= start_count + 1;
				bus_active <= 1'b1;
				scl_rises <= 0;
			end
			// A stop follows whole bytes of nine clocks and the one SCL rise of the stop
			if (scl_prev && scl_line && !sda_prev && sda_line) begin
				assert (bus_active && scl_rises >= 10 && scl_rises % 9 == 1)
					else report_error("stop condition in the middle of a byte");
				stop_count <= stop_count + 1;
				bus_active <= 1'b0;
			end
		end
	end

	function automatic logic [31:0] tx_word(input logic [7:0] data, input logic last);
		return {23'h0, last, data};
	endfunction

	function automatic logic [31:0] rx_entry(input logic first, input logic [7:0] data);
		return {22'h0, 1'b1, first, data};
	endfunction

	// Row is address bits 6:3, the allow bit inside it is address bits 2:0
	function automatic logic [31:0] match_word(input logic [6:0] addr);
		logic [7:0] bits;
		bits = 8'd1 << addr[2:0];
		return {16'h0, bits, 4'h0, addr[6:3]};
	endfunction

	function automatic logic [31:0] status_word(input logic busy, input logic nack,
			input logic full, input logic empty, input logic overflow);
		logic [31:0] w;
		w = '0;
		w[status_busy] = busy;
		w[status_last_nack] = nack;
		w[status_tx_full] = full;
		w[status_rx_empty] = empty;
		w[status_rx_overflow] = overflow;
		return w;
	endfunction

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic axi_write(input logic [3:0] addr, input logic [31:0] data);
		req.awvalid = 1'b1;
		req.awaddr = addr;
		req.wvalid = 1'b1;
		req.wdata = data;
		@(posedge clk);
		while (!(rsp.awready && rsp.wready))
			@(posedge clk);
		#1;
		req.awvalid = 1'b0;
		req.wvalid = 1'b0;
		req.bready = 1'b1;
		@(posedge clk);
		while (!rsp.bvalid)
			@(posedge clk);
		check_value("bresp", {30'h0, axi_okay}, {30'h0, rsp.bresp});
		#1;
		req.bready = 1'b0;
	endtask

	task automatic axi_read(input logic [3:0] addr, output logic [31:0] data);
		req.arvalid = 1'b1;
		req.araddr = addr;
		@(posedge clk);
		while (!rsp.arready)
			@(posedge clk);
		#1;
		req.arvalid = 1'b0;
		req.rready = 1'b1;
		@(posedge clk);
		while (!rsp.rvalid)
			@(posedge clk);
		data = rsp.rdata;
		check_value("rresp", {30'h0, axi_okay}, {30'h0, rsp.rresp});
		#1;
		req.rready = 1'b0;
	endtask

	task automatic read_check(input logic [3:0] addr, input string what,
			input logic [31:0] expected);
		logic [31:0] data;
		axi_read(addr, data);
		check_value(what, expected, data);
	endtask

	task automatic send_address(input logic [6:0] addr);
		axi_write(reg_tx_data, tx_word({addr, 1'b0}, 1'b0));
		issued++;
	endtask

	task automatic wait_stops(input int n);
		while (stop_count < n)
			@(posedge clk);
		#1;
	endtask

	task automatic wait_idle();
		logic [31:0] data;
		axi_read(reg_status, data);
		while (data[status_busy])
			axi_read(reg_status, data);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		errors_at_start = error_count;
	endtask

	task automatic end_test();
		tests_run++;
		if (error_count == errors_at_start) begin
			$display("Test %s: ok", test_name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", test_name, error_count - errors_at_start);
		end
	endtask

	initial begin
		seed = 31632;
		reset = 1'b1;
		req = '0;
		test_name = "reset";
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;

		begin_test("after_reset");
		read_check(reg_status, "status", status_word(0, 0, 0, 1, 0));
		read_check(reg_rx_data, "rx_data", 32'h0);
		end_test();

		begin_test("allowed_transfer");
		axi_write(reg_match_row, match_word(allowed_addr));
		send_address(allowed_addr);
		for (int i = 0; i < 3; i++) begin
			sent[i] = 8'($random(seed));
			axi_write(reg_tx_data, tx_word(sent[i], i == 2));
		end
		wait_stops(issued);
		wait_idle();
		read_check(reg_rx_data, "address entry", rx_entry(1'b1, {allowed_addr, 1'b0}));
		for (int i = 0; i < 3; i++)
			read_check(reg_rx_data, "data entry", rx_entry(1'b0, sent[i]));
		read_check(reg_status, "status", status_word(0, 0, 0, 1, 0));
		end_test();

		begin_test("blocked_address");
		send_address(blocked_addr);
		sent[0] = 8'($random(seed));
		axi_write(reg_tx_data, tx_word(sent[0], 1'b1));
		wait_stops(issued);
		wait_idle();
		read_check(reg_status, "status", status_word(0, 1, 0, 1, 0));
		read_check(reg_rx_data, "rx_data", 32'h0);
		check_value("start conditions", issued, start_count);
		end_test();

		begin_test("bus_hold");
		send_address(allowed_addr);
		wait_cycles(12 * bit_cycles);
		read_check(reg_status, "status during hold", status_word(1, 0, 0, 0, 0));
		high_cycles = 0;
		repeat (4 * bit_cycles) begin
			@(posedge clk);
			if (scl_line)
				high_cycles++;
		end
		#1;
		check_value("SCL high cycles during hold", 0, high_cycles);
		sent[0] = 8'($random(seed));
		axi_write(reg_tx_data, tx_word(sent[0], 1'b1));
		wait_stops(issued);
		wait_idle();
		read_check(reg_rx_data, "address entry", rx_entry(1'b1, {allowed_addr, 1'b0}));
		read_check(reg_rx_data, "data entry", rx_entry(1'b0, sent[0]));
		read_check(reg_status, "status", status_word(0, 0, 0, 1, 0));
		end_test();

		// Seven bytes into a four entry queue, so the last three are dropped
		begin_test("rx_overflow");
		send_address(allowed_addr);
		for (int i = 0; i < 6; i++) begin
			sent[i] = 8'($random(seed));
			axi_write(reg_tx_data, tx_word(sent[i], i == 5));
		end
		wait_stops(issued);
		axi_read(reg_status, word);
		check_value("rx_overflow set", 32'h1, {31'h0, word[status_rx_overflow]});
		axi_read(reg_status, word);
		check_value("rx_overflow cleared", 32'h0, {31'h0, word[status_rx_overflow]});
		read_check(reg_rx_data, "address entry", rx_entry(1'b1, {allowed_addr, 1'b0}));
		for (int i = 0; i < 3; i++)
			read_check(reg_rx_data, "data entry", rx_entry(1'b0, sent[i]));
		read_check(reg_rx_data, "rx_data after drain", 32'h0);
		wait_idle();
		end_test();

		begin_test("line_balance");
		check_value("start conditions", issued, start_count);
		check_value("stop conditions", issued, stop_count);
		end_test();

		$display("Tests run %0d, tests failed %0d, errors %0d",
			tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

// ==== i2c_bridge.f ====
i2c_bus_pkg.sv
host_reg_pkg.sv
byte_fifo.sv
axil_host_regs.sv
i2c_master_tx.sv
i2c_bus_monitor.sv
i2c_bridge_top.sv
tb_i2c_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
set -u
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert -f i2c_bridge.f --top-module tb_i2c_bridge \
	-Mdir "$build_dir" -o tb_i2c_bridge
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$build_dir/tb_i2c_bridge" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Simulation finished: PASS$" "$log"; then
	exit 0
fi
exit 1
